// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

   localparam int XLEN = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // Major opcodes
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LUI    = 7'b0110111,
      AUIPC  = 7'b0010111,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111,
      BRANCH = 7'b1100011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011
   } opcode_t;

   localparam logic [2:0] FUNC_LB   = 3'b000;
   localparam logic [2:0] FUNC_LH   = 3'b001;
   localparam logic [2:0] FUNC_LW   = 3'b010;
   localparam logic [2:0] FUNC_LBU  = 3'b100;
   localparam logic [2:0] FUNC_LHU  = 3'b101;
   localparam logic [2:0] FUNC_SB   = 3'b000;
   localparam logic [2:0] FUNC_SH   = 3'b001;
   localparam logic [2:0] FUNC_SW   = 3'b010;
   localparam logic [2:0] FUNC_BEQ  = 3'b000;
   localparam logic [2:0] FUNC_BNE  = 3'b001;
   localparam logic [2:0] FUNC_BLT  = 3'b100;
   localparam logic [2:0] FUNC_BGE  = 3'b101;
   localparam logic [2:0] FUNC_BLTU = 3'b110;
   localparam logic [2:0] FUNC_BGEU = 3'b111;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
      ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
   } alu_op_t;

   typedef enum logic [2:0] {
      BUS_READB, BUS_READBU, BUS_READH, BUS_READHU,
      BUS_READW, BUS_WRITEB, BUS_WRITEH, BUS_WRITEW
   } bus_op_t;

   typedef enum logic {SRC1_REG, SRC1_PC} src1_sel_t;
   typedef enum logic [1:0] {SRC2_REG, SRC2_IMM, SRC2_FOUR} src2_sel_t;
   typedef enum logic [1:0] {WB_ALU, WB_BUS, WB_IMM, WB_NONE} wb_sel_t;

   typedef enum logic [2:0] {
      NEXT_FETCH, NEXT_LOAD, NEXT_STORE, NEXT_BRANCH, NEXT_HALT
   } exec_next_t;

   // Bit order eq, ne, lt, ge, ltu, geu from bit 0 up
   typedef logic [5:0] branch_mask_t;

   typedef enum logic [3:0] {
      ST_RESET, ST_PRE_FETCH, ST_FETCH, ST_DECODE, ST_EXEC, ST_POST_EXEC,
      ST_LOAD1, ST_LOAD2, ST_STORE1, ST_STORE2, ST_BRANCH, ST_UPDATE_PC, ST_HALT
   } state_t;

endpackage

`default_nettype wire

// File: design/rv_alu.sv
`default_nettype none

module rv_alu (
   input  wire rv_pkg::word_t   a_i,
   input  wire rv_pkg::word_t   b_i,
   input  wire rv_pkg::alu_op_t op_i,
   output rv_pkg::word_t        result_o,
   output logic                 eq_o,
   output logic                 lt_o,
   output logic                 ltu_o
);

   logic [4:0] shamt;

   assign shamt = b_i[4:0];

   // Flags for the branch test
   assign eq_o = (a_i == b_i);
   assign lt_o = ($signed(a_i) < $signed(b_i));
   assign ltu_o = (a_i < b_i);

   always_comb begin
      case (op_i)
         rv_pkg::ALU_ADD:  result_o = a_i + b_i;
         rv_pkg::ALU_SUB:  result_o = a_i - b_i;
         rv_pkg::ALU_SLL:  result_o = a_i << shamt;
         rv_pkg::ALU_SLT:  result_o = {{(rv_pkg::XLEN-1){1'b0}}, lt_o};
         rv_pkg::ALU_SLTU: result_o = {{(rv_pkg::XLEN-1){1'b0}}, ltu_o};
         rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
         rv_pkg::ALU_SRL:  result_o = a_i >> shamt;
         rv_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
         rv_pkg::ALU_OR:   result_o = a_i | b_i;
         rv_pkg::ALU_AND:  result_o = a_i & b_i;
         default:          result_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`default_nettype none

module rv_regfile (
   input  wire                    clk,
   input  wire rv_pkg::reg_addr_t rs1_i,
   input  wire rv_pkg::reg_addr_t rs2_i,
   input  wire rv_pkg::reg_addr_t rd_i,
   input  wire                    rd_en_i,
   input  wire                    we_i,
   input  wire rv_pkg::word_t     wdata_i,
   output rv_pkg::word_t          rdata1_o,
   output rv_pkg::word_t          rdata2_o
);

   // Entry 0 is never written
   rv_pkg::word_t regs [0:31];

   always_ff @(posedge clk) begin
      if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rdata1_o <= (rs1_i == '0) ? '0 : regs[rs1_i];
         rdata2_o <= (rs2_i == '0) ? '0 : regs[rs2_i];
      end
   end

endmodule

`default_nettype wire

// File: design/rv_decoder.sv
`default_nettype none

module rv_decoder (
   input  wire                      clk,
   input  wire                      dec_en_i,
   input  wire rv_pkg::word_t       instr_i,
   output rv_pkg::reg_addr_t        rs1_o,
   output rv_pkg::reg_addr_t        rs2_o,
   output rv_pkg::reg_addr_t        rd_o,
   output rv_pkg::word_t            imm_o,
   output rv_pkg::alu_op_t          alu_op_o,
   output rv_pkg::src1_sel_t        src1_sel_o,
   output rv_pkg::src2_sel_t        src2_sel_o,
   output rv_pkg::wb_sel_t          wb_sel_o,
   output logic                     next_pc_from_alu_o,
   output rv_pkg::branch_mask_t     branch_mask_o,
   output rv_pkg::exec_next_t       next_o,
   output logic [2:0]               funct3_o
);

   rv_pkg::opcode_t opcode;
   logic [2:0] funct3;
   rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

   assign opcode = rv_pkg::opcode_t'(instr_i[6:0]);
   assign funct3 = instr_i[14:12];

   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
   assign imm_u = {instr_i[31:12], 12'b0};
   assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

   // Shared by OP and OP_IMM, alt picks SUB or SRA
   function automatic rv_pkg::alu_op_t alu_func(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  alu_func = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
         3'b001:  alu_func = rv_pkg::ALU_SLL;
         3'b010:  alu_func = rv_pkg::ALU_SLT;
         3'b011:  alu_func = rv_pkg::ALU_SLTU;
         3'b100:  alu_func = rv_pkg::ALU_XOR;
         3'b101:  alu_func = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
         3'b110:  alu_func = rv_pkg::ALU_OR;
         default: alu_func = rv_pkg::ALU_AND;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (dec_en_i) begin
         rs1_o <= instr_i[19:15];
         rs2_o <= instr_i[24:20];
         rd_o <= instr_i[11:7];
         funct3_o <= funct3;
         imm_o <= imm_i;
         alu_op_o <= rv_pkg::ALU_ADD;
         src1_sel_o <= rv_pkg::SRC1_REG;
         src2_sel_o <= rv_pkg::SRC2_IMM;
         wb_sel_o <= rv_pkg::WB_NONE;
         next_pc_from_alu_o <= 1'b0;
         branch_mask_o <= '0;
         next_o <= rv_pkg::NEXT_HALT;

         case (opcode)
            rv_pkg::OP: begin
               alu_op_o <= alu_func(funct3, instr_i[30]);
               src2_sel_o <= rv_pkg::SRC2_REG;
               wb_sel_o <= rv_pkg::WB_ALU;
               next_o <= rv_pkg::NEXT_FETCH;
            end
            rv_pkg::OP_IMM: begin
               // bit 30 is part of the immediate except for shifts
               alu_op_o <= alu_func(funct3, (funct3 == 3'b101) && instr_i[30]);
               wb_sel_o <= rv_pkg::WB_ALU;
               next_o <= rv_pkg::NEXT_FETCH;
            end
            rv_pkg::LUI: begin
               imm_o <= imm_u;
               wb_sel_o <= rv_pkg::WB_IMM;
               next_o <= rv_pkg::NEXT_FETCH;
            end
            rv_pkg::AUIPC: begin
               imm_o <= imm_u;
               src1_sel_o <= rv_pkg::SRC1_PC;
               wb_sel_o <= rv_pkg::WB_ALU;
               next_o <= rv_pkg::NEXT_FETCH;
            end
            rv_pkg::JAL: begin
               imm_o <= imm_j;
               src1_sel_o <= rv_pkg::SRC1_PC;
               wb_sel_o <= rv_pkg::WB_ALU;
               next_pc_from_alu_o <= 1'b1;
               next_o <= rv_pkg::NEXT_FETCH;
            end
            rv_pkg::JALR: begin
               wb_sel_o <= rv_pkg::WB_ALU;
               next_pc_from_alu_o <= 1'b1;
               next_o <= rv_pkg::NEXT_FETCH;
            end
            rv_pkg::BRANCH: begin
               imm_o <= imm_b;
               src2_sel_o <= rv_pkg::SRC2_REG;
               alu_op_o <= rv_pkg::ALU_SUB;
               next_o <= rv_pkg::NEXT_BRANCH;
               case (funct3)
                  rv_pkg::FUNC_BEQ:  branch_mask_o <= 6'b000001;
                  rv_pkg::FUNC_BNE:  branch_mask_o <= 6'b000010;
                  rv_pkg::FUNC_BLT:  branch_mask_o <= 6'b000100;
                  rv_pkg::FUNC_BGE:  branch_mask_o <= 6'b001000;
                  rv_pkg::FUNC_BLTU: branch_mask_o <= 6'b010000;
                  rv_pkg::FUNC_BGEU: branch_mask_o <= 6'b100000;
                  default:           next_o <= rv_pkg::NEXT_HALT;
               endcase
            end
            rv_pkg::LOAD: begin
               wb_sel_o <= rv_pkg::WB_BUS;
               if (funct3 == rv_pkg::FUNC_LB || funct3 == rv_pkg::FUNC_LH ||
                   funct3 == rv_pkg::FUNC_LW || funct3 == rv_pkg::FUNC_LBU ||
                   funct3 == rv_pkg::FUNC_LHU) begin
                  next_o <= rv_pkg::NEXT_LOAD;
               end
            end
            rv_pkg::STORE: begin
               imm_o <= imm_s;
               if (funct3 == rv_pkg::FUNC_SB || funct3 == rv_pkg::FUNC_SH ||
                   funct3 == rv_pkg::FUNC_SW) begin
                  next_o <= rv_pkg::NEXT_STORE;
               end
            end
            default: begin
               next_o <= rv_pkg::NEXT_HALT;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/rv_bus_master.sv
`default_nettype none

module rv_bus_master (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  en_i,
   input  wire rv_pkg::bus_op_t op_i,
   input  wire rv_pkg::word_t   addr_i,
   input  wire rv_pkg::word_t   wdata_i,
   output rv_pkg::word_t        rdata_o,
   output logic                 busy_o,
   input  wire                  wb_ack_i,
   input  wire rv_pkg::word_t   wb_dat_i,
   output rv_pkg::word_t        wb_adr_o,
   output rv_pkg::word_t        wb_dat_o,
   output logic [3:0]           wb_sel_o,
   output logic                 wb_cyc_o,
   output logic                 wb_stb_o,
   output logic                 wb_we_o
);

   rv_pkg::bus_op_t op_q;
   logic [1:0] lane_q;
   logic [3:0] sel;
   rv_pkg::word_t lane_data;
   rv_pkg::word_t shifted;
   rv_pkg::word_t load_data;
   logic is_write;

   assign is_write = (op_i == rv_pkg::BUS_WRITEB) || (op_i == rv_pkg::BUS_WRITEH) ||
                     (op_i == rv_pkg::BUS_WRITEW);

   // Byte lanes and store data replication
   always_comb begin
      case (op_i)
         rv_pkg::BUS_READB, rv_pkg::BUS_READBU, rv_pkg::BUS_WRITEB: begin
            sel = 4'b0001 << addr_i[1:0];
            lane_data = {4{wdata_i[7:0]}};
         end
         rv_pkg::BUS_READH, rv_pkg::BUS_READHU, rv_pkg::BUS_WRITEH: begin
            sel = addr_i[1] ? 4'b1100 : 4'b0011;
            lane_data = {2{wdata_i[15:0]}};
         end
         default: begin
            sel = 4'b1111;
            lane_data = wdata_i;
         end
      endcase
   end

   // ==============================
   // Load extension
   assign shifted = wb_dat_i >> {lane_q, 3'b000};

   always_comb begin
      case (op_q)
         rv_pkg::BUS_READB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
         rv_pkg::BUS_READBU: load_data = {24'b0, shifted[7:0]};
         rv_pkg::BUS_READH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
         rv_pkg::BUS_READHU: load_data = {16'b0, shifted[15:0]};
         default:            load_data = wb_dat_i;
      endcase
   end

   // ==============================
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_cyc_o <= 1'b0;
         wb_we_o <= 1'b0;
      end else if (en_i) begin
         wb_cyc_o <= 1'b1;
         wb_we_o <= is_write;
      end else if (wb_cyc_o && wb_ack_i) begin
         wb_cyc_o <= 1'b0;
         wb_we_o <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (en_i) begin
         op_q <= op_i;
         lane_q <= addr_i[1:0];
         wb_adr_o <= {addr_i[31:2], 2'b00};
         wb_sel_o <= sel;
         wb_dat_o <= lane_data;
      end
      if (wb_cyc_o && wb_ack_i && !wb_we_o) begin
         rdata_o <= load_data;
      end
   end

   assign wb_stb_o = wb_cyc_o;
   assign busy_o = wb_cyc_o;

endmodule

`default_nettype wire

// File: design/rv_core.sv
`default_nettype none

module rv_core #(
   parameter rv_pkg::word_t reset_vector = '0
) (
   input  wire                clk,
   input  wire                reset,
   input  wire                wb_ack_i,
   input  wire rv_pkg::word_t wb_dat_i,
   output rv_pkg::word_t      wb_adr_o,
   output rv_pkg::word_t      wb_dat_o,
   output logic [3:0]         wb_sel_o,
   output logic               wb_cyc_o,
   output logic               wb_stb_o,
   output logic               wb_we_o,
   output logic               halted_o
);

   rv_pkg::state_t state, state_nxt;
   rv_pkg::word_t pc, pc_next, instr_q;

   // Decoder outputs
   rv_pkg::reg_addr_t dec_rd;
   rv_pkg::word_t dec_imm;
   rv_pkg::alu_op_t dec_alu_op;
   rv_pkg::src1_sel_t dec_src1_sel;
   rv_pkg::src2_sel_t dec_src2_sel;
   rv_pkg::wb_sel_t dec_wb_sel;
   logic dec_next_pc_from_alu;
   rv_pkg::branch_mask_t dec_branch_mask;
   rv_pkg::exec_next_t dec_next;
   logic [2:0] dec_funct3;
   logic dec_en;

   rv_pkg::word_t rdata1, rdata2, rf_wdata;
   logic rd_en, rf_we;

   rv_pkg::src1_sel_t src1_sel;
   rv_pkg::src2_sel_t src2_sel;
   rv_pkg::alu_op_t alu_op;
   rv_pkg::word_t alu_a, alu_b, alu_result;
   logic alu_eq, alu_lt, alu_ltu;
   logic eq_q, lt_q, ltu_q;
   logic branch_taken;

   logic bus_en, bus_busy;
   rv_pkg::bus_op_t bus_op;
   rv_pkg::word_t bus_addr, bus_data;

   rv_decoder decoder_inst (
      .clk(clk), .dec_en_i(dec_en), .instr_i(instr_q),
      .rs1_o(), .rs2_o(), .rd_o(dec_rd), .imm_o(dec_imm),
      .alu_op_o(dec_alu_op), .src1_sel_o(dec_src1_sel), .src2_sel_o(dec_src2_sel),
      .wb_sel_o(dec_wb_sel), .next_pc_from_alu_o(dec_next_pc_from_alu),
      .branch_mask_o(dec_branch_mask), .next_o(dec_next), .funct3_o(dec_funct3)
   );

   // Read indices come straight from the fetch word, the decoder latches in parallel
   rv_regfile regfile_inst (
      .clk(clk), .rs1_i(instr_q[19:15]), .rs2_i(instr_q[24:20]), .rd_i(dec_rd),
      .rd_en_i(rd_en), .we_i(rf_we), .wdata_i(rf_wdata),
      .rdata1_o(rdata1), .rdata2_o(rdata2)
   );

   rv_alu alu_inst (
      .a_i(alu_a), .b_i(alu_b), .op_i(alu_op),
      .result_o(alu_result), .eq_o(alu_eq), .lt_o(alu_lt), .ltu_o(alu_ltu)
   );

   rv_bus_master bus_inst (
      .clk(clk), .reset(reset), .en_i(bus_en), .op_i(bus_op),
      .addr_i(bus_addr), .wdata_i(rdata2), .rdata_o(bus_data), .busy_o(bus_busy),
      .wb_ack_i(wb_ack_i), .wb_dat_i(wb_dat_i), .wb_adr_o(wb_adr_o),
      .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o), .wb_cyc_o(wb_cyc_o),
      .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o)
   );

   // ==============================
   // Operand muxes
   always_comb begin
      src1_sel = dec_src1_sel;
      src2_sel = dec_src2_sel;
      alu_op = dec_alu_op;
      case (state)
         rv_pkg::ST_PRE_FETCH, rv_pkg::ST_FETCH: begin
            src1_sel = rv_pkg::SRC1_PC;
            src2_sel = rv_pkg::SRC2_FOUR;
            alu_op = rv_pkg::ALU_ADD;
         end
         rv_pkg::ST_BRANCH: begin
            src1_sel = rv_pkg::SRC1_PC;
            src2_sel = rv_pkg::SRC2_IMM;
            alu_op = rv_pkg::ALU_ADD;
         end
         default: ;
      endcase
      alu_a = (src1_sel == rv_pkg::SRC1_PC) ? pc : rdata1;
      case (src2_sel)
         rv_pkg::SRC2_REG: alu_b = rdata2;
         rv_pkg::SRC2_IMM: alu_b = dec_imm;
         default:          alu_b = 32'd4;
      endcase
   end

   // Jumps link with pc + 4 from fetch, the ALU then holds the target
   always_comb begin
      case (dec_wb_sel)
         rv_pkg::WB_BUS: rf_wdata = bus_data;
         rv_pkg::WB_IMM: rf_wdata = dec_imm;
         default:        rf_wdata = dec_next_pc_from_alu ? pc_next : alu_result;
      endcase
   end

   assign branch_taken = |(dec_branch_mask & {~ltu_q, ltu_q, ~lt_q, lt_q, ~eq_q, eq_q});
   assign bus_addr = (state == rv_pkg::ST_PRE_FETCH) ? pc : alu_result;
   assign halted_o = (state == rv_pkg::ST_HALT);

   // ==============================
   // Control FSM
   always_comb begin
      state_nxt = state;
      bus_en = 1'b0;
      bus_op = rv_pkg::BUS_READW;
      dec_en = 1'b0;
      rd_en = 1'b0;
      rf_we = 1'b0;
      case (state)
         rv_pkg::ST_RESET: state_nxt = rv_pkg::ST_PRE_FETCH;
         rv_pkg::ST_PRE_FETCH: begin
            bus_en = 1'b1;
            state_nxt = rv_pkg::ST_FETCH;
         end
         rv_pkg::ST_FETCH: state_nxt = rv_pkg::ST_DECODE;
         rv_pkg::ST_DECODE: begin
            dec_en = 1'b1;
            rd_en = 1'b1;
            state_nxt = rv_pkg::ST_EXEC;
         end
         rv_pkg::ST_EXEC: begin
            case (dec_next)
               rv_pkg::NEXT_FETCH:  state_nxt = rv_pkg::ST_POST_EXEC;
               rv_pkg::NEXT_LOAD:   state_nxt = rv_pkg::ST_LOAD1;
               rv_pkg::NEXT_STORE:  state_nxt = rv_pkg::ST_STORE1;
               rv_pkg::NEXT_BRANCH: state_nxt = rv_pkg::ST_BRANCH;
               default:             state_nxt = rv_pkg::ST_HALT;
            endcase
         end
         rv_pkg::ST_LOAD1: begin
            bus_en = 1'b1;
            case (dec_funct3)
               rv_pkg::FUNC_LB:  bus_op = rv_pkg::BUS_READB;
               rv_pkg::FUNC_LBU: bus_op = rv_pkg::BUS_READBU;
               rv_pkg::FUNC_LH:  bus_op = rv_pkg::BUS_READH;
               rv_pkg::FUNC_LHU: bus_op = rv_pkg::BUS_READHU;
               default:          bus_op = rv_pkg::BUS_READW;
            endcase
            state_nxt = rv_pkg::ST_LOAD2;
         end
         rv_pkg::ST_STORE1: begin
            bus_en = 1'b1;
            case (dec_funct3)
               rv_pkg::FUNC_SB: bus_op = rv_pkg::BUS_WRITEB;
               rv_pkg::FUNC_SH: bus_op = rv_pkg::BUS_WRITEH;
               default:         bus_op = rv_pkg::BUS_WRITEW;
            endcase
            state_nxt = rv_pkg::ST_STORE2;
         end
         rv_pkg::ST_POST_EXEC, rv_pkg::ST_LOAD2, rv_pkg::ST_STORE2, rv_pkg::ST_BRANCH: begin
            state_nxt = rv_pkg::ST_UPDATE_PC;
         end
         rv_pkg::ST_UPDATE_PC: begin
            rf_we = (dec_wb_sel != rv_pkg::WB_NONE);
            state_nxt = rv_pkg::ST_PRE_FETCH;
         end
         default: state_nxt = rv_pkg::ST_HALT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= rv_pkg::ST_RESET;
         pc <= reset_vector;
      end else if (!bus_busy) begin
         state <= state_nxt;
         if (state == rv_pkg::ST_UPDATE_PC) begin
            pc <= dec_next_pc_from_alu ? {alu_result[rv_pkg::XLEN-1:1], 1'b0} : pc_next;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!bus_busy) begin
         case (state)
            rv_pkg::ST_FETCH: begin
               instr_q <= bus_data;
               pc_next <= alu_result;
            end
            rv_pkg::ST_EXEC: begin
               eq_q <= alu_eq;
               lt_q <= alu_lt;
               ltu_q <= alu_ltu;
            end
            rv_pkg::ST_BRANCH: begin
               if (branch_taken) begin
                  pc_next <= alu_result;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: tests/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

   localparam int NT = 11;
   localparam int CYCLE_LIMIT = NT * 400;

   logic clk, reset, ack, we, cyc, stb, halted;
   logic [31:0] rdata, adr, wdata;
   logic [3:0] sel;

   logic [31:0] mem [0:255];
   logic [31:0] prog [NT][12];
   logic [31:0] data [NT][2];
   // Expected write as {address, data, byte select}
   logic [67:0] exp_wr [NT][4];
   int n_exp [NT];
   bit halt_row [NT];

   int cur, seen, test_errors, cycles, delay_left;
   bit in_cycle;
   logic [31:0] rnd;

   tb_clock clock_inst (.clk_o(clk));

   rv_core #(.reset_vector(32'h0)) rv_core_inst (
      .clk(clk), .reset(reset), .wb_ack_i(ack), .wb_dat_i(rdata),
      .wb_adr_o(adr), .wb_dat_o(wdata), .wb_sel_o(sel), .wb_cyc_o(cyc),
      .wb_stb_o(stb), .wb_we_o(we), .halted_o(halted)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic compare_write();
      logic [67:0] e;
      if (seen >= n_exp[cur]) begin
         $display("Unexpected write at time %0t to %h with data %h", $time, adr, wdata);
         test_errors++;
      end else begin
         e = exp_wr[cur][seen];
         if (adr !== e[67:36]) begin
            $display("Error at %0t: wb_adr_o = %h, expected %h", $time, adr, e[67:36]);
            test_errors++;
         end
         if (wdata !== e[35:4]) begin
            $display("Error at %0t: wb_dat_o = %h, expected %h", $time, wdata, e[35:4]);
            test_errors++;
         end
         if (sel !== e[3:0]) begin
            $display("Error at %0t: wb_sel_o = %h, expected %h", $time, sel, e[3:0]);
            test_errors++;
         end
         seen++;
      end
   endtask

   // ==============================
   // Memory model with random ack delay
   always @(posedge clk) begin
      #1;
      if (!reset && stb !== cyc) begin
         $display("Strobe differs from cycle at time %0t", $time);
         test_errors++;
      end
      if (reset || ack) begin
         ack = 1'b0;
         in_cycle = 1'b0;
      end else if (cyc && stb) begin
         if (!in_cycle) begin
            in_cycle = 1'b1;
            rnd = xorshift(rnd);
            delay_left = int'(rnd % 4);
         end
         if (delay_left == 0) begin
            if (we) begin
               for (int b = 0; b < 4; b++) begin
                  if (sel[b]) mem[adr[9:2]][8*b +: 8] = wdata[8*b +: 8];
               end
               compare_write();
            end else begin
               rdata = mem[adr[9:2]];
            end
            ack = 1'b1;
         end else begin
            delay_left--;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic fill_table();
      for (int t = 0; t < NT; t++) begin
         data[t] = '{32'h0, 32'h0};
         halt_row[t] = 1'b0;
      end
      // Arithmetic
      prog[0] = '{32'h10000513, 32'hFFB00093, 32'h00300113, 32'h002082B3,
                  32'h40208333, 32'h0020A3B3, 32'h0020B433, 32'h00552023,
                  32'h00652223, 32'h00752423, 32'h00852623, 32'h0000006F};
      exp_wr[0] = '{{32'h100, 32'hFFFFFFFE, 4'hF}, {32'h104, 32'hFFFFFFF8, 4'hF},
                    {32'h108, 32'h1, 4'hF}, {32'h10C, 32'h0, 4'hF}};
      // Shifts and xor
      prog[1] = '{32'h10000513, 32'hFF000093, 32'h4020D293, 32'h01C0D313,
                  32'h00431393, 32'h00734433, 32'h00552023, 32'h00652223,
                  32'h00752423, 32'h00852623, 32'h0000006F, 32'h0};
      exp_wr[1] = '{{32'h100, 32'hFFFFFFFC, 4'hF}, {32'h104, 32'hF, 4'hF},
                    {32'h108, 32'hF0, 4'hF}, {32'h10C, 32'hFF, 4'hF}};
      // OR, AND, x0 write ignored, SLL by register
      prog[2] = '{32'h10000513, 32'h5A500093, 32'h0FF00113, 32'h0020E2B3,
                  32'h0020F333, 32'h00700013, 32'h00211433, 32'h00552023,
                  32'h00652223, 32'h00052423, 32'h00852623, 32'h0000006F};
      exp_wr[2] = '{{32'h100, 32'h5FF, 4'hF}, {32'h104, 32'hA5, 4'hF},
                    {32'h108, 32'h0, 4'hF}, {32'h10C, 32'h80000000, 4'hF}};
      // LB, LBU, LH, LHU
      prog[3] = '{32'h10000513, 32'h08000593, 32'h00058283, 32'h0035C303,
                  32'h00259383, 32'h0025D403, 32'h00552023, 32'h00652223,
                  32'h00752423, 32'h00852623, 32'h0000006F, 32'h0};
      data[3] = '{32'hC3A57F81, 32'h0};
      exp_wr[3] = '{{32'h100, 32'hFFFFFF81, 4'hF}, {32'h104, 32'hC3, 4'hF},
                    {32'h108, 32'hFFFFC3A5, 4'hF}, {32'h10C, 32'hC3A5, 4'hF}};
      // SB to each byte lane
      prog[4] = '{32'h10000513, 32'h7AB00293, 32'h00550023, 32'h005500A3,
                  32'h00550123, 32'h005501A3, 32'h0000006F, 32'h0,
                  32'h0, 32'h0, 32'h0, 32'h0};
      exp_wr[4] = '{{32'h100, 32'hABABABAB, 4'h1}, {32'h100, 32'hABABABAB, 4'h2},
                    {32'h100, 32'hABABABAB, 4'h4}, {32'h100, 32'hABABABAB, 4'h8}};
      // LW, then SH to both halves and SW
      prog[5] = '{32'h10000513, 32'h08000593, 32'h0045A283, 32'h00551023,
                  32'h00551323, 32'h00552423, 32'h0000006F, 32'h0,
                  32'h0, 32'h0, 32'h0, 32'h0};
      data[5] = '{32'h0, 32'h0BADF00D};
      exp_wr[5] = '{{32'h100, 32'hF00DF00D, 4'h3}, {32'h104, 32'hF00DF00D, 4'hC},
                    {32'h108, 32'h0BADF00D, 4'hF}, 68'h0};
      // Taken branches skip a wrong store
      prog[6] = '{32'h10000513, 32'hFFF00093, 32'h00100113, 32'h0020C463,
                  32'h00152023, 32'h0020E463, 32'h00252023, 32'h00108463,
                  32'h00252223, 32'h00109463, 32'h00152223, 32'h0000006F};
      prog[7] = '{32'h10000513, 32'hFFF00093, 32'h00100113, 32'h00115463,
                  32'h00152023, 32'h00117463, 32'h00252023, 32'h0020F463,
                  32'h00252223, 32'h0020D463, 32'h00152223, 32'h0000006F};
      prog[8] = '{32'h10000513, 32'hFFF00093, 32'h00100113, 32'h00116463,
                  32'h00152023, 32'h00114463, 32'h00252023, 32'h00209463,
                  32'h00252223, 32'h00208463, 32'h00152223, 32'h0000006F};
      for (int t = 6; t <= 8; t++) begin
         exp_wr[t] = '{{32'h100, 32'h1, 4'hF}, {32'h104, 32'hFFFFFFFF, 4'hF},
                       68'h0, 68'h0};
      end
      // LUI, AUIPC, JAL and JALR links
      prog[9] = '{32'h10000513, 32'h123452B7, 32'h00001317, 32'h008003EF,
                  32'h00052023, 32'h00C38467, 32'h00052023, 32'h00552023,
                  32'h00652223, 32'h00752423, 32'h00852623, 32'h0000006F};
      exp_wr[9] = '{{32'h100, 32'h12345000, 4'hF}, {32'h104, 32'h1008, 4'hF},
                    {32'h108, 32'h10, 4'hF}, {32'h10C, 32'h18, 4'hF}};
      // Unknown opcode
      prog[10] = '{32'h10000513, 32'h00A52023, 32'hFFFFFFFF, 32'h00A52223,
                   32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
      exp_wr[10] = '{{32'h100, 32'h100, 4'hF}, 68'h0, 68'h0, 68'h0};
      halt_row[10] = 1'b1;
      n_exp = '{4, 4, 4, 4, 4, 3, 2, 2, 2, 4, 1};
   endtask

   task automatic run_test(input int t);
      @(posedge clk);
      #1;
      reset = 1'b1;
      for (int i = 0; i < 256; i++) begin
         mem[i] = 32'h5EED0000 | i;
      end
      for (int i = 0; i < 12; i++) begin
         mem[i] = prog[t][i];
      end
      mem[32] = data[t][0];
      mem[33] = data[t][1];
      cur = t;
      seen = 0;
      test_errors = 0;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      // First fetch two cycles after reset falls
      @(posedge clk);
      #1;
      if (cyc) begin
         $display("Bus cycle started one cycle too early after reset");
         test_errors++;
      end
      @(posedge clk);
      #1;
      if (!cyc) begin
         $display("No bus cycle two cycles after reset");
         test_errors++;
      end
      if (adr !== 32'h0) begin
         $display("Error at %0t: wb_adr_o = %h, expected %h", $time, adr, 32'h0);
         test_errors++;
      end
      if (we !== 1'b0) begin
         $display("Error at %0t: wb_we_o = %b, expected %b", $time, we, 1'b0);
         test_errors++;
      end
      while (!(seen >= n_exp[t] && (!halt_row[t] || halted))) begin
         @(posedge clk);
         #2;
      end
      if (!halt_row[t] && halted !== 1'b0) begin
         $display("Error at %0t: halted_o = %b, expected %b", $time, halted, 1'b0);
         test_errors++;
      end
      if (halt_row[t]) begin
         repeat (20) begin
            @(posedge clk);
            #2;
            if (cyc) begin
               $display("Bus cycle issued after the core halted");
               test_errors++;
            end
         end
      end
   endtask

   initial begin
      int passed;
      int failed;
      passed = 0;
      failed = 0;
      reset = 1'b1;
      ack = 1'b0;
      rdata = 32'h0;
      rnd = 32'hfc45;
      cycles = 0;
      in_cycle = 1'b0;
      delay_left = 0;
      fill_table();
      for (int t = 0; t < NT; t++) begin
         run_test(t);
         if (test_errors == 0) begin
            passed++;
            $display("test %0d: ok", t);
         end else begin
            failed++;
            $display("test %0d: %0d mismatches", t, test_errors);
         end
      end
      $display("Summary: %0d tests passed, %0d tests failed", passed, failed);
      if (failed == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
design/rv_pkg.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_decoder.sv
design/rv_bus_master.sv
design/rv_core.sv
tests/tb_clock.sv
tests/tb_rv_core.sv

// File: Makefile
.PHONY: compile run clean

compile: obj_dir/Vtb_rv_core

obj_dir/Vtb_rv_core: list.f design/*.sv tests/*.sv
	verilator --binary --timing -j 0 --top-module tb_rv_core -f list.f

run: compile
	./obj_dir/Vtb_rv_core | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
